// ==== include/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// ----------------------------------------------------------------------
// core widths, fixed by RV64I
// ----------------------------------------------------------------------

`define RV_XLEN   64  // data and pc width
`define RV_ILEN   32  // instruction width
`define RV_NREGS  32  // architectural registers incl. x0

`endif

// ==== design/rv_isa_pkg.sv ====
`default_nettype none

`include "rv_cfg.svh"

package rv_isa_pkg;

    typedef logic [`RV_ILEN-1:0] inst_t;
    typedef logic [4:0]          reg_idx_t;

    localparam int unsigned SHAMT_W = $clog2(`RV_XLEN);  // 6 bits for rv64

    // major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_OP_IMM_W = 7'b0011011,
        OPC_OP_W     = 7'b0111011
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU  // branch compares
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_kind_e;

endpackage

`default_nettype wire

// ==== design/rv_pipe_pkg.sv ====
`default_nettype none

`include "rv_cfg.svh"

package rv_pipe_pkg;

    import rv_isa_pkg::*;

    typedef logic [`RV_XLEN-1:0] xlen_t;

    // ----------------------------------------------------------------------
    // stage buses
    // ----------------------------------------------------------------------

    typedef struct packed {
        inst_t inst;
        xlen_t pc;
    } fetch_bus_t;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     a_is_pc;    // operand a from pc
        logic     a_is_zero;  // operand a forced to 0 (lui)
        logic     b_is_imm;
        logic     reg_wen;
        logic     link;       // result is pc+4
        logic     is_branch;
        logic     is_jalr;
        logic     illegal;
        reg_idx_t rd;
        xlen_t    imm;
        xlen_t    src1;
        xlen_t    src2;
        xlen_t    pc;
    } dec_bus_t;

    typedef struct packed {
        logic     wen;
        reg_idx_t waddr;
        xlen_t    wdata;
    } wb_bus_t;

    // one record per retired instruction
    typedef struct packed {
        xlen_t    pc;
        reg_idx_t rd;
        xlen_t    wdata;
        logic     wen;
        logic     br_taken;
        xlen_t    br_target;
        logic     illegal;
    } res_bus_t;

endpackage

`default_nettype wire

// ==== design/inst_fetch_buf.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_fetch_buf
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       in_valid_i,
    input  wire inst_t      inst_i,
    input  wire xlen_t      pc_i,
    output logic            in_allowin_o,
    input  wire logic       ds_allowin_i,
    output logic            fs_valid_o,
    output fetch_bus_t      fs_bus_o
);

    logic       fs_valid;
    logic       fs_allowin;
    fetch_bus_t fs_bus_r;  // payload, no reset

    // nothing to wait for here, so ready_go is always high
    assign fs_allowin = !fs_valid || ds_allowin_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= in_valid_i;
        end
        if (in_valid_i && fs_allowin) begin
            fs_bus_r <= '{inst: inst_i, pc: pc_i};
        end
    end

    assign in_allowin_o = fs_allowin;
    assign fs_valid_o   = fs_valid;
    assign fs_bus_o     = fs_bus_r;

endmodule

`default_nettype wire

// ==== design/inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decode
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       fs_valid_i,
    input  wire fetch_bus_t fs_bus_i,
    output logic            ds_allowin_o,
    input  wire logic       es_allowin_i,
    output logic            ds_valid_o,
    output dec_bus_t        ds_bus_o,
    output reg_idx_t        raddr1_o,
    output reg_idx_t        raddr2_o,
    input  wire xlen_t      rdata1_i,
    input  wire xlen_t      rdata2_i,
    input  wire logic       es_valid_i,
    input  wire logic       es_reg_wen_i,
    input  wire reg_idx_t   es_rd_i
);

    logic       ds_valid;
    logic       ds_ready_go;
    fetch_bus_t ds_fb;

    always_ff @(posedge clk) begin
        if (rst) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin_o) begin
            ds_valid <= fs_valid_i;
        end
        if (fs_valid_i && ds_allowin_o) begin
            ds_fb <= fs_bus_i;
        end
    end

    // ----------------------------------------------------------------------
    // field split and immediates
    // ----------------------------------------------------------------------

    inst_t     inst;
    opcode_e   opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t  rs1, rs2;
    imm_kind_e imm_kind;
    xlen_t     imm;
    logic      use_rs1, use_rs2;
    dec_bus_t  dec;

    assign inst   = ds_fb.inst;
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        case (imm_kind)
            IMM_I:   imm = xlen_t'($signed(inst[31:20]));
            IMM_S:   imm = xlen_t'($signed({inst[31:25], inst[11:7]}));
            IMM_B:   imm = xlen_t'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
            IMM_U:   imm = xlen_t'($signed({inst[31:12], 12'b0}));
            IMM_J:   imm = xlen_t'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
            default: imm = '0;  // r-type
        endcase
    end

    // ----------------------------------------------------------------------
    // control decode
    // ----------------------------------------------------------------------

    always_comb begin
        dec      = '0;
        imm_kind = IMM_NONE;
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        case (opcode)
            OPC_LUI: begin
                imm_kind      = IMM_U;
                dec.a_is_zero = 1'b1;
                dec.b_is_imm  = 1'b1;
                dec.reg_wen   = 1'b1;
            end
            OPC_AUIPC, OPC_JAL: begin
                imm_kind     = (opcode == OPC_JAL) ? IMM_J : IMM_U;
                dec.a_is_pc  = 1'b1;
                dec.b_is_imm = 1'b1;
                dec.reg_wen  = 1'b1;
                dec.link     = (opcode == OPC_JAL);  // target from the alu sum
            end
            OPC_JALR: begin
                imm_kind     = IMM_I;
                use_rs1      = 1'b1;
                dec.b_is_imm = 1'b1;
                dec.reg_wen  = 1'b1;
                dec.link     = 1'b1;
                dec.is_jalr  = 1'b1;
                dec.illegal  = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                imm_kind      = IMM_B;
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                dec.is_branch = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = ALU_BEQ;
                    3'b001:  dec.alu_op = ALU_BNE;
                    3'b100:  dec.alu_op = ALU_BLT;
                    3'b101:  dec.alu_op = ALU_BGE;
                    3'b110:  dec.alu_op = ALU_BLTU;
                    3'b111:  dec.alu_op = ALU_BGEU;
                    default: dec.illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                imm_kind     = IMM_I;
                use_rs1      = 1'b1;
                dec.b_is_imm = 1'b1;
                dec.reg_wen  = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = ALU_ADD;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b111:  dec.alu_op = ALU_AND;
                    3'b011:  dec.alu_op = ALU_SLTU;
                    3'b001: begin
                        dec.alu_op  = ALU_SLL;
                        dec.illegal = (inst[31:26] != 6'b000000);
                    end
                    3'b101: begin
                        dec.alu_op  = inst[30] ? ALU_SRA : ALU_SRL;
                        dec.illegal = ({inst[31], inst[29:26]} != 5'b00000);
                    end
                    default: dec.illegal = 1'b1;  // slti, ori not in the set
                endcase
            end
            OPC_OP: begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                dec.reg_wen = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: dec.alu_op = ALU_ADD;
                    10'b0100000_000: dec.alu_op = ALU_SUB;
                    10'b0000000_111: dec.alu_op = ALU_AND;
                    10'b0000000_110: dec.alu_op = ALU_OR;
                    10'b0000000_010: dec.alu_op = ALU_SLT;
                    10'b0000000_011: dec.alu_op = ALU_SLTU;
                    default:         dec.illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM_W: begin
                imm_kind     = IMM_I;
                use_rs1      = 1'b1;
                dec.b_is_imm = 1'b1;
                dec.reg_wen  = 1'b1;
                dec.alu_op   = ALU_ADDW;
                dec.illegal  = (funct3 != 3'b000);  // addiw only
            end
            OPC_OP_W: begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                dec.reg_wen = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: dec.alu_op = ALU_ADDW;
                    10'b0100000_000: dec.alu_op = ALU_SUBW;
                    default:         dec.illegal = 1'b1;
                endcase
            end
            default: dec.illegal = 1'b1;
        endcase
        // an illegal word writes nothing and waits on nothing
        if (dec.illegal) begin
            dec.reg_wen = 1'b0;
            use_rs1     = 1'b0;
            use_rs2     = 1'b0;
        end
        dec.rd   = inst[11:7];
        dec.imm  = imm;
        dec.src1 = rdata1_i;
        dec.src2 = rdata2_i;
        dec.pc   = ds_fb.pc;
    end

    // ----------------------------------------------------------------------
    // raw hazard against execute, no bypass
    // ----------------------------------------------------------------------

    logic raw_hazard;

    assign raw_hazard = es_valid_i && es_reg_wen_i && (es_rd_i != '0) &&
                        ((use_rs1 && rs1 == es_rd_i) || (use_rs2 && rs2 == es_rd_i));

    assign ds_ready_go  = !raw_hazard;
    assign ds_allowin_o = !ds_valid || (ds_ready_go && es_allowin_i);
    assign ds_valid_o   = ds_valid && ds_ready_go;
    assign ds_bus_o     = dec;
    assign raddr1_o     = rs1;  // combinational read
    assign raddr2_o     = rs2;

endmodule

`default_nettype wire

// ==== design/gpr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_cfg.svh"

module gpr_file
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire reg_idx_t raddr1_i,
    input  wire reg_idx_t raddr2_i,
    output xlen_t         rdata1_o,
    output xlen_t         rdata2_o,
    input  wire wb_bus_t  wb_i
);

    xlen_t regs [1:`RV_NREGS-1];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.wen && wb_i.waddr != '0) begin
            regs[wb_i.waddr] <= wb_i.wdata;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

// ==== design/exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_stage
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     ds_valid_i,
    input  wire dec_bus_t ds_bus_i,
    output logic          es_allowin_o,
    input  wire logic     res_ready_i,
    output logic          res_valid_o,
    output res_bus_t      res_bus_o,
    output wb_bus_t       wb_o,
    output logic          es_valid_o,
    output logic          es_reg_wen_o,
    output reg_idx_t      es_rd_o
);

    logic     es_valid;
    dec_bus_t es_r;

    assign es_allowin_o = !es_valid || res_ready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            es_valid <= 1'b0;
        end else if (es_allowin_o) begin
            es_valid <= ds_valid_i;
        end
        if (ds_valid_i && es_allowin_o) begin
            es_r <= ds_bus_i;
        end
    end

    function automatic xlen_t sext32(input logic [31:0] w);
        return xlen_t'($signed(w));
    endfunction

    // ----------------------------------------------------------------------
    // alu
    // ----------------------------------------------------------------------

    xlen_t              op_a, op_b, sum, diff, alu_res;
    logic [SHAMT_W-1:0] shamt;

    assign op_a  = es_r.a_is_zero ? '0 : (es_r.a_is_pc ? es_r.pc : es_r.src1);
    assign op_b  = es_r.b_is_imm ? es_r.imm : es_r.src2;
    assign sum   = op_a + op_b;
    assign diff  = op_a - op_b;
    assign shamt = op_b[SHAMT_W-1:0];

    always_comb begin
        case (es_r.alu_op)
            ALU_SUB:  alu_res = diff;
            ALU_AND:  alu_res = op_a & op_b;
            ALU_OR:   alu_res = op_a | op_b;
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
            ALU_SLT:  alu_res = xlen_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_res = xlen_t'(op_a < op_b);
            ALU_ADDW: alu_res = sext32(sum[31:0]);
            ALU_SUBW: alu_res = sext32(diff[31:0]);
            default:  alu_res = sum;  // add, jump targets
        endcase
    end

    // branch compare works on the raw register values
    logic br_cond;

    always_comb begin
        case (es_r.alu_op)
            ALU_BEQ:  br_cond = (es_r.src1 == es_r.src2);
            ALU_BNE:  br_cond = (es_r.src1 != es_r.src2);
            ALU_BLT:  br_cond = ($signed(es_r.src1) < $signed(es_r.src2));
            ALU_BGE:  br_cond = ($signed(es_r.src1) >= $signed(es_r.src2));
            ALU_BLTU: br_cond = (es_r.src1 < es_r.src2);
            ALU_BGEU: br_cond = (es_r.src1 >= es_r.src2);
            default:  br_cond = 1'b0;
        endcase
    end

    // ----------------------------------------------------------------------
    // result record and write-back
    // ----------------------------------------------------------------------

    xlen_t jump_target;
    logic  res_wen;

    assign jump_target = es_r.is_jalr ? {alu_res[$bits(xlen_t)-1:1], 1'b0} : alu_res;
    assign res_wen     = es_r.reg_wen && (es_r.rd != '0);  // x0 writes dropped

    always_comb begin
        res_bus_o.pc        = es_r.pc;
        res_bus_o.rd        = es_r.rd;
        res_bus_o.wdata     = es_r.link ? es_r.pc + 64'd4 : alu_res;
        res_bus_o.wen       = res_wen;
        res_bus_o.br_taken  = es_r.is_branch ? br_cond : es_r.link;
        res_bus_o.illegal   = es_r.illegal;
        if (es_r.is_branch) begin
            res_bus_o.br_target = es_r.pc + es_r.imm;  // reported taken or not
        end else if (es_r.link) begin
            res_bus_o.br_target = jump_target;
        end else begin
            res_bus_o.br_target = '0;
        end
    end

    assign res_valid_o  = es_valid;
    assign wb_o.wen     = es_valid && res_ready_i && res_wen;  // only on the leaving edge
    assign wb_o.waddr   = es_r.rd;
    assign wb_o.wdata   = res_bus_o.wdata;
    assign es_valid_o   = es_valid;
    assign es_reg_wen_o = es_r.reg_wen;
    assign es_rd_o      = es_r.rd;

endmodule

`default_nettype wire

// ==== design/decode_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_core
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  in_valid_i,
    input  wire inst_t inst_i,
    input  wire xlen_t pc_i,
    output logic       in_allowin_o,
    output logic       res_valid_o,
    output res_bus_t   res_bus_o,
    input  wire logic  res_ready_i
);

    // fetch buffer to decode
    logic       fs_valid, ds_allowin;
    fetch_bus_t fs_bus;

    // decode to execute
    logic       ds_valid, es_allowin;
    dec_bus_t   ds_bus;

    // register file and hazard paths
    reg_idx_t   raddr1, raddr2, es_rd;
    xlen_t      rdata1, rdata2;
    wb_bus_t    wb_bus;
    logic       es_valid, es_reg_wen;

    inst_fetch_buf u_fetch_buf (
        .clk          (clk),
        .rst          (rst),
        .in_valid_i   (in_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .in_allowin_o (in_allowin_o),
        .ds_allowin_i (ds_allowin),
        .fs_valid_o   (fs_valid),
        .fs_bus_o     (fs_bus)
    );

    inst_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .fs_valid_i   (fs_valid),
        .fs_bus_i     (fs_bus),
        .ds_allowin_o (ds_allowin),
        .es_allowin_i (es_allowin),
        .ds_valid_o   (ds_valid),
        .ds_bus_o     (ds_bus),
        .raddr1_o     (raddr1),
        .raddr2_o     (raddr2),
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .es_valid_i   (es_valid),
        .es_reg_wen_i (es_reg_wen),
        .es_rd_i      (es_rd)
    );

    gpr_file u_gpr (
        .clk      (clk),
        .rst      (rst),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .wb_i     (wb_bus)
    );

    exec_stage u_exec (
        .clk          (clk),
        .rst          (rst),
        .ds_valid_i   (ds_valid),
        .ds_bus_i     (ds_bus),
        .es_allowin_o (es_allowin),
        .res_ready_i  (res_ready_i),
        .res_valid_o  (res_valid_o),
        .res_bus_o    (res_bus_o),
        .wb_o         (wb_bus),
        .es_valid_o   (es_valid),
        .es_reg_wen_o (es_reg_wen),
        .es_rd_o      (es_rd)
    );

endmodule

`default_nettype wire

// ==== tests/decode_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_core_tb
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
();

    localparam int    TIMEOUT      = 200;  // cycles per wait
    localparam int    RESET_CYCLES = 5;
    localparam xlen_t TBL_BASE     = 64'h1000;

    typedef struct packed {
        inst_t    inst;
        res_bus_t exp;  // pc is the issue pc
    } entry_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     in_valid_i;
    inst_t    inst_i;
    xlen_t    pc_i;
    logic     in_allowin_o;
    logic     res_valid_o;
    res_bus_t res_bus_o;
    logic     res_ready_i;

    entry_t      table_q [$];
    xlen_t       tbl_pc    = TBL_BASE;
    logic [31:0] rdy_state = 32'hd171;
    logic [31:0] gap_state = 32'hd171;
    int          chain_first  = 0;  // first entry of the dependent chain
    int          err_cnt      = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    logic        aborted      = 1'b0;  // a wait timed out

    decode_core decode_core_i (
        .clk          (clk),
        .rst          (rst),
        .in_valid_i   (in_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .in_allowin_o (in_allowin_o),
        .res_valid_o  (res_valid_o),
        .res_bus_o    (res_bus_o),
        .res_ready_i  (res_ready_i)
    );

    always #2 clk = ~clk;  // 4 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // random back-pressure, about one cycle in four
    always @(posedge clk) begin
        if (rst) begin
            res_ready_i <= 1'b1;
        end else begin
            rdy_state = lcg_next(rdy_state);
            res_ready_i <= (rdy_state[31:30] != 2'b00);
        end
    end

    // ----------------------------------------------------------------------
    // instruction encoders
    // ----------------------------------------------------------------------

    function automatic inst_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                    input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic inst_t enc_r(input logic [6:0] opc, input logic [6:0] f7,
                                    input logic [2:0] f3, input int rd, input int rs1,
                                    input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic inst_t enc_u(input logic [6:0] opc, input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    function automatic inst_t enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                    input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic inst_t enc_j(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    // ----------------------------------------------------------------------
    // stimulus and expected values
    // ----------------------------------------------------------------------

    task automatic add_entry(input inst_t inst, input int rd, input xlen_t wdata,
                             input logic wen, input logic taken, input xlen_t target,
                             input logic illegal);
        entry_t e;
        e.inst          = inst;
        e.exp.pc        = tbl_pc;
        e.exp.rd        = rd[4:0];
        e.exp.wdata     = wdata;
        e.exp.wen       = wen;
        e.exp.br_taken  = taken;
        e.exp.br_target = target;
        e.exp.illegal   = illegal;
        table_q.push_back(e);
        tbl_pc = tbl_pc + 64'd4;
    endtask

    task automatic build_table;
        add_entry(enc_u(OPC_LUI, 1, 'h12345), 1, 64'h12345000, 1'b1, 1'b0, '0, 1'b0);
        add_entry(enc_u(OPC_AUIPC, 2, 'h1), 2, 64'h2004, 1'b1, 1'b0, '0, 1'b0);
        add_entry(enc_i(OPC_OP_IMM, 3'b000, 3, 0, -1), 3, 64'hffffffffffffffff,
                  1'b1, 1'b0, '0, 1'b0);
        add_entry(enc_i(OPC_OP_IMM, 3'b111, 4, 3, 'h0f0), 4, 64'hf0, 1'b1, 1'b0, '0, 1'b0);
        add_entry(enc_i(OPC_OP_IMM, 3'b100, 5, 4, 'h0ff), 5, 64'h0f, 1'b1, 1'b0, '0, 1'b0);
        add_entry(enc_i(OPC_OP_IMM, 3'b001, 6, 5, 60), 6, 64'hf000000000000000,
                  1'b1, 1'b0, '0, 1'b0);  // slli
        add_entry(enc_i(OPC_OP_IMM, 3'b101, 7, 6, 'h004), 7, 64'h0f00000000000000,
                  1'b1, 1'b0, '0, 1'b0);  // srli
        add_entry(enc_i(OPC_OP_IMM, 3'b101, 8, 6, 'h404), 8, 64'hff00000000000000,
                  1'b1, 1'b0, '0, 1'b0);  // srai
        add_entry(enc_i(OPC_OP_IMM, 3'b011, 9, 5, 16), 9, 64'd1, 1'b1, 1'b0, '0, 1'b0);
        add_entry(enc_u(OPC_LUI, 11, 'h80000), 11, 64'hffffffff80000000, 1'b1, 1'b0, '0, 1'b0);
        add_entry(enc_i(OPC_OP_IMM_W, 3'b000, 12, 11, -1), 12, 64'h7fffffff,
                  1'b1, 1'b0, '0, 1'b0);  // word wraps positive
        add_entry(enc_r(OPC_OP_W, 7'b0000000, 3'b000, 13, 12, 12), 13, 64'hfffffffffffffffe,
                  1'b1, 1'b0, '0, 1'b0);
        add_entry(enc_r(OPC_OP_W, 7'b0100000, 3'b000, 14, 0, 12), 14, 64'hffffffff80000001,
                  1'b1, 1'b0, '0, 1'b0);
        add_entry(enc_r(OPC_OP, 7'b0000000, 3'b000, 15, 1, 2), 15, 64'h12347004,
                  1'b1, 1'b0, '0, 1'b0);
        add_entry(enc_r(OPC_OP, 7'b0100000, 3'b000, 16, 2, 1), 16, 64'hffffffffedcbd004,
                  1'b1, 1'b0, '0, 1'b0);
        add_entry(enc_r(OPC_OP, 7'b0000000, 3'b111, 17, 3, 1), 17, 64'h12345000,
                  1'b1, 1'b0, '0, 1'b0);
        add_entry(enc_r(OPC_OP, 7'b0000000, 3'b110, 18, 4, 5), 18, 64'hff, 1'b1, 1'b0, '0, 1'b0);
        add_entry(enc_r(OPC_OP, 7'b0000000, 3'b010, 19, 3, 0), 19, 64'd1, 1'b1, 1'b0, '0, 1'b0);
        add_entry(enc_r(OPC_OP, 7'b0000000, 3'b011, 20, 0, 3), 20, 64'd1, 1'b1, 1'b0, '0, 1'b0);
        // back-to-back chain on x22
        chain_first = table_q.size();
        add_entry(enc_i(OPC_OP_IMM, 3'b000, 22, 0, 5), 22, 64'd5, 1'b1, 1'b0, '0, 1'b0);
        add_entry(enc_i(OPC_OP_IMM, 3'b000, 22, 22, 7), 22, 64'd12, 1'b1, 1'b0, '0, 1'b0);
        add_entry(enc_r(OPC_OP, 7'b0000000, 3'b000, 22, 22, 22), 22, 64'd24,
                  1'b1, 1'b0, '0, 1'b0);
        // branches, target reported even when not taken
        add_entry(enc_b(3'b000, 4, 4, 16), 0, '0, 1'b0, 1'b1, tbl_pc + 64'd16, 1'b0);
        add_entry(enc_b(3'b001, 4, 4, -8), 0, '0, 1'b0, 1'b0, tbl_pc - 64'd8, 1'b0);
        add_entry(enc_b(3'b100, 3, 0, 32), 0, '0, 1'b0, 1'b1, tbl_pc + 64'd32, 1'b0);
        add_entry(enc_b(3'b101, 3, 0, 32), 0, '0, 1'b0, 1'b0, tbl_pc + 64'd32, 1'b0);
        add_entry(enc_b(3'b110, 3, 0, 64), 0, '0, 1'b0, 1'b0, tbl_pc + 64'd64, 1'b0);
        add_entry(enc_b(3'b111, 3, 0, -4096), 0, '0, 1'b0, 1'b1, tbl_pc - 64'd4096, 1'b0);
        add_entry(enc_j(23, 2048), 23, tbl_pc + 64'd4, 1'b1, 1'b1, tbl_pc + 64'd2048, 1'b0);
        add_entry(enc_i(OPC_JALR, 3'b000, 24, 1, 7), 24, tbl_pc + 64'd4, 1'b1, 1'b1,
                  64'h12345006, 1'b0);  // bit 0 cleared
        // ori and a load are outside the set
        add_entry(enc_i(OPC_OP_IMM, 3'b110, 27, 5, 1), 27, '0, 1'b0, 1'b0, '0, 1'b1);
        add_entry(enc_i(7'b0000011, 3'b011, 28, 0, 0), 28, '0, 1'b0, 1'b0, '0, 1'b1);
        add_entry(enc_i(OPC_OP_IMM, 3'b000, 0, 3, 5), 0, '0, 1'b0, 1'b0, '0, 1'b0);
        add_entry(enc_i(OPC_OP_IMM, 3'b000, 25, 0, 'h55), 25, 64'h55, 1'b1, 1'b0, '0, 1'b0);
        add_entry(enc_r(OPC_OP, 7'b0000000, 3'b000, 26, 23, 24), 26, 64'h20ec,
                  1'b1, 1'b0, '0, 1'b0);  // both link values
    endtask

    // ----------------------------------------------------------------------
    // checks and reporting
    // ----------------------------------------------------------------------

    task automatic report_mismatch(input int idx, input string field, input xlen_t got,
                                   input xlen_t exp);
        $display("ERROR @%0t: entry %0d %s is %h, expected %h", $time, idx, field, got, exp);
        err_cnt++;
    endtask

    task automatic check_wb(input int idx, input res_bus_t got, input res_bus_t exp);
        if (got.pc !== exp.pc) report_mismatch(idx, "pc", got.pc, exp.pc);
        if (got.wen !== exp.wen) report_mismatch(idx, "wen", xlen_t'(got.wen), xlen_t'(exp.wen));
        if (got.illegal !== exp.illegal) begin
            report_mismatch(idx, "illegal", xlen_t'(got.illegal), xlen_t'(exp.illegal));
        end
        // rd and wdata only mean something when a register is written
        if (exp.wen) begin
            if (got.rd !== exp.rd) report_mismatch(idx, "rd", xlen_t'(got.rd), xlen_t'(exp.rd));
            if (got.wdata !== exp.wdata) report_mismatch(idx, "wdata", got.wdata, exp.wdata);
        end
    endtask

    task automatic check_br(input int idx, input res_bus_t got, input res_bus_t exp);
        if (got.br_taken !== exp.br_taken) begin
            report_mismatch(idx, "br_taken", xlen_t'(got.br_taken), xlen_t'(exp.br_taken));
        end
        if (got.br_target !== exp.br_target) begin
            report_mismatch(idx, "br_target", got.br_target, exp.br_target);
        end
    endtask

    task automatic check_ctrl(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR @%0t: %s is %b, expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string what, input int errs_before);
        tests_run++;
        if (err_cnt == errs_before) begin
            $display("[%0t] %s passed", $time, what);
        end else begin
            tests_failed++;
            $display("[%0t] %s FAILED", $time, what);
        end
    endtask

    task automatic stop_on_stall(input string why);
        $display("%0t: %s", $time, why);
        err_cnt++;
        aborted = 1'b1;
    endtask

    // ----------------------------------------------------------------------
    // feeder and checker
    // ----------------------------------------------------------------------

    task automatic feed_entries;
        int unsigned gap;
        logic        taken;
        for (int i = 0; i < table_q.size() && !aborted; i++) begin
            gap_state = lcg_next(gap_state);
            gap = int'(gap_state[29:28]) % 3;
            if (i > chain_first && i <= chain_first + 2) begin
                gap = 0;  // dependents follow their producer directly
            end
            if (gap != 0) begin
                in_valid_i <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            in_valid_i <= 1'b1;
            inst_i     <= table_q[i].inst;
            pc_i       <= table_q[i].exp.pc;
            taken = 1'b0;
            for (int c = 0; c < TIMEOUT && !taken && !aborted; c++) begin
                @(posedge clk);
                taken = in_allowin_o;  // value seen by the dut at this edge
            end
            if (!taken && !aborted) begin
                stop_on_stall($sformatf("input stalled: entry %0d never accepted", i));
            end
        end
        in_valid_i <= 1'b0;
    endtask

    task automatic check_results;
        logic got;
        int   errs_before;
        for (int i = 0; i < table_q.size() && !aborted; i++) begin
            got = 1'b0;
            for (int c = 0; c < TIMEOUT && !got && !aborted; c++) begin
                @(posedge clk);
                got = res_valid_o && res_ready_i;
            end
            if (got) begin
                errs_before = err_cnt;
                check_wb(i, res_bus_o, table_q[i].exp);
                check_br(i, res_bus_o, table_q[i].exp);
                report_test($sformatf("entry %0d inst %h", i, table_q[i].inst), errs_before);
            end else if (!aborted) begin
                stop_on_stall($sformatf("pipeline stalled: no result for entry %0d", i));
            end
        end
        if (!aborted) begin
            errs_before = err_cnt;
            for (int c = 0; c < 20; c++) begin
                @(posedge clk);
                if (res_valid_o) begin
                    $display("ERROR @%0t: result record beyond the end of the table", $time);
                    err_cnt++;
                end
            end
            report_test("no extra records", errs_before);
        end
    endtask

    task automatic finish_run;
        $display("tests run %0d, failed %0d, error count %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    initial begin
        int errs_before;
        rst         = 1'b1;
        in_valid_i  = 1'b0;
        inst_i      = '0;
        pc_i        = '0;
        res_ready_i = 1'b1;
        build_table();
        errs_before = err_cnt;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i > 0) begin  // flops settle after the first edge
                check_ctrl("res_valid_o in reset", res_valid_o, 1'b0);
                check_ctrl("in_allowin_o in reset", in_allowin_o, 1'b1);
            end
        end
        rst <= 1'b0;
        @(posedge clk);
        check_ctrl("res_valid_o after reset", res_valid_o, 1'b0);
        check_ctrl("in_allowin_o after reset", in_allowin_o, 1'b1);
        report_test("reset state", errs_before);
        fork
            feed_entries();
            check_results();
        join
        finish_run();
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/inst_fetch_buf.sv
design/inst_decode.sv
design/gpr_file.sv
design/exec_stage.sv
design/decode_core.sv
tests/decode_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f src.f \
    --top-module decode_core_tb -o decode_core_sim \
    && ./obj_dir/decode_core_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
